// ==== rtl/zx_tape_pkg.sv ====
// Tape fast-loader package for the ZX80/ZX81 replica
// Shared widths, trap addresses, patch bytes and bus types

package zx_tape_pkg;

	// ========================================================================
	// Widths and sizes
	// ========================================================================
	localparam int TAPE_AW    = 14;
	localparam int TAPE_DEPTH = 16384;
	localparam int RAM_AW     = 16;
	localparam int PATCH_LEN  = 7;

	// Trap addresses and first address past each load window
	localparam logic [15:0] ZX81_TRAP_ADDR = 16'h0347;
	localparam logic [15:0] ZX81_WIN_END   = 16'h03C3;
	localparam logic [15:0] ZX80_TRAP_ADDR = 16'h0207;
	localparam logic [15:0] ZX80_WIN_END   = 16'h024D;

	// Where the image lands in RAM; .p images skip the system variables
	localparam logic [15:0] RAM_LOAD_BASE = 16'h4000;
	localparam logic [15:0] P_FILE_OFFSET = 16'd9;

	// ========================================================================
	// Types
	// ========================================================================
	typedef logic [7:0]         tape_byte_t;
	typedef logic [TAPE_AW-1:0] tape_idx_t;

	typedef enum logic {
		TAPE_O = 1'b0,
		TAPE_P = 1'b1
	} tape_kind_t;

	typedef enum logic [1:0] {
		LD_IDLE  = 2'd0,
		LD_COPY  = 2'd1,
		LD_DRAIN = 2'd2
	} loader_state_t;

	typedef struct packed {
		logic        fetch;
		logic [15:0] addr;
	} cpu_fetch_t;

	typedef struct packed {
		tape_byte_t data;
		logic       last;
		tape_kind_t kind;
	} dl_beat_t;

	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		tape_byte_t        data;
	} ram_wr_t;

	typedef struct packed {
		logic       active;
		tape_byte_t data;
	} mem_ovr_t;

	// ========================================================================
	// Loader patch
	// ========================================================================
	// xor a / nop or scf / jr nc,-3 / jp 02xxh
	localparam tape_byte_t [0:PATCH_LEN-1] PATCH_INIT =
		'{8'hAF, 8'h00, 8'h30, 8'hFD, 8'hC3, 8'h07, 8'h02};

	localparam tape_byte_t OP_NOP        = 8'h00;
	localparam tape_byte_t OP_SCF        = 8'h37;
	localparam tape_byte_t ZX81_JUMP_LOW = 8'h07;
	localparam tape_byte_t ZX80_JUMP_LOW = 8'h03;

endpackage

// ==== rtl/tape_buffer.sv ====
// Tape buffer
// Stores the downloaded image, records its size and kind, registered read port

`timescale 1ns/1ns

module tape_buffer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_valid,
	input  zx_tape_pkg::dl_beat_t  dl_beat,
	output logic                   dl_ready,
	input  logic                   accept_en,
	input  zx_tape_pkg::tape_idx_t rd_idx,
	output zx_tape_pkg::tape_byte_t rd_data,
	output zx_tape_pkg::tape_idx_t tape_size,
	output zx_tape_pkg::tape_kind_t tape_kind,
	output logic                   tape_ready
);
	import zx_tape_pkg::*;

	tape_byte_t mem [TAPE_DEPTH];
	tape_idx_t  wr_idx;
	logic       accept;

	// Host is held off while the CPU is being fed from the buffer
	assign dl_ready = accept_en;
	assign accept   = dl_valid & accept_en;

	// Byte storage
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			mem[wr_idx] <= dl_beat.data;
		end
	end

	// Write index, size and kind capture
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_idx    <= '0;
			tape_size <= '0;
			tape_kind <= TAPE_O;
		end else if (accept) begin
			if (dl_beat.last) begin
				// Next image starts over at byte 0
				wr_idx    <= '0;
				tape_size <= wr_idx + 1'b1;
				tape_kind <= dl_beat.kind;
			end else begin
				wr_idx <= wr_idx + 1'b1;
			end
		end
	end

	// Something to load once a complete image has arrived
	assign tape_ready = (tape_size != '0);

	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_idx];
	end

endmodule

// ==== rtl/tape_addr_counter.sv ====
// Tape byte index counter
// Counts bytes already copied to RAM and flags the end of the tape

`timescale 1ns/1ns

module tape_addr_counter (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   clear,
	input  logic                   step,
	input  zx_tape_pkg::tape_idx_t size,
	output zx_tape_pkg::tape_idx_t idx,
	output logic                   at_end
);

	// Clear wins over step, a new trap restarts the copy
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idx <= '0;
		end else if (clear) begin
			idx <= '0;
		end else if (step) begin
			idx <= idx + 1'b1;
		end
	end

	// All bytes copied once the index reaches the size
	assign at_end = (idx == size);

endmodule

// ==== rtl/tape_loader_fsm.sv ====
// Tape loader FSM
// Detects the load-routine trap, paces the byte copy and ends the trap

`timescale 1ns/1ns

module tape_loader_fsm (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  zx_tape_pkg::cpu_fetch_t     cpu_fetch,
	input  logic                        zx81,
	input  logic                        ce_cpu_p,
	input  logic                        tape_ready,
	input  logic                        at_end,
	input  logic                        wr_busy,
	output zx_tape_pkg::loader_state_t  state,
	output logic                        loading,
	output logic                        cnt_clear,
	output logic                        fetch_req
);
	import zx_tape_pkg::*;

	loader_state_t state_nxt;
	logic [15:0]   trap_addr;
	logic [15:0]   win_end;
	logic          trap_hit;
	logic          win_exit;

	// ========================================================================
	// Model select
	// ========================================================================
	assign trap_addr = zx81 ? ZX81_TRAP_ADDR : ZX80_TRAP_ADDR;
	assign win_end   = zx81 ? ZX81_WIN_END : ZX80_WIN_END;

	assign trap_hit = cpu_fetch.fetch & (cpu_fetch.addr == trap_addr) & tape_ready;

	// Any fetch outside the load routine means the ROM has moved on
	assign win_exit = cpu_fetch.fetch &
		((cpu_fetch.addr < trap_addr) | (cpu_fetch.addr >= win_end));

	// ========================================================================
	// State sequencing
	// ========================================================================
	always_comb begin
		state_nxt = state;
		case (state)
			LD_IDLE: begin
				if (trap_hit) begin
					state_nxt = LD_COPY;
				end
			end
			LD_COPY: begin
				if (win_exit) begin
					state_nxt = LD_IDLE;
				end else if (at_end) begin
					state_nxt = LD_DRAIN;
				end
			end
			LD_DRAIN: begin
				if (win_exit) begin
					state_nxt = LD_IDLE;
				end
			end
			default: begin
				state_nxt = LD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= LD_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign loading = (state != LD_IDLE);

	// Counter restart and patch rewrite on trap entry
	assign cnt_clear = (state == LD_IDLE) & trap_hit;

	// One byte per CPU clock enable, never more than one in flight
	assign fetch_req = (state == LD_COPY) & ce_cpu_p & ~wr_busy & ~at_end;

endmodule

// ==== rtl/loader_patch.sv ====
// Loader patch
// Seven-byte loop served in place of the ROM load routine while trapped

`timescale 1ns/1ns

module loader_patch (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_tape_pkg::cpu_fetch_t cpu_fetch,
	input  logic                    zx81,
	input  logic                    loading,
	input  logic                    trap_enter,
	input  logic                    at_end,
	output zx_tape_pkg::mem_ovr_t   mem_ovr
);
	import zx_tape_pkg::*;

	tape_byte_t [0:PATCH_LEN-1] patch_q;
	logic [15:0]                trap_addr;
	logic [15:0]                offset;

	assign trap_addr = zx81 ? ZX81_TRAP_ADDR : ZX80_TRAP_ADDR;

	// Byte 1 spins as NOP until the copy is done, then SCF breaks the loop.
	// Byte 5 is the low byte of the jump back into the ROM.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			patch_q <= PATCH_INIT;
		end else if (trap_enter) begin
			patch_q[1] <= OP_NOP;
			patch_q[5] <= zx81 ? ZX81_JUMP_LOW : ZX80_JUMP_LOW;
		end else if (loading && at_end) begin
			patch_q[1] <= OP_SCF;
		end
	end

	// ========================================================================
	// Memory read override
	// ========================================================================
	assign offset = cpu_fetch.addr - trap_addr;

	always_comb begin
		mem_ovr.active = loading;
		if (offset < 16'(PATCH_LEN)) begin
			mem_ovr.data = patch_q[offset[2:0]];
		end else begin
			// Open bus outside the patch
			mem_ovr.data = 8'hFF;
		end
	end

endmodule

// ==== rtl/tape_ram_writer.sv ====
// Tape RAM writer
// Takes one tape byte from the buffer and offers it to RAM under valid/ready

`timescale 1ns/1ns

module tape_ram_writer (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    fetch_req,
	input  zx_tape_pkg::tape_byte_t rd_data,
	input  zx_tape_pkg::tape_idx_t  idx,
	input  zx_tape_pkg::tape_kind_t kind,
	output logic                    ram_wr_valid,
	output zx_tape_pkg::ram_wr_t    ram_wr,
	input  logic                    ram_wr_ready,
	output logic                    busy,
	output logic                    wr_done
);
	import zx_tape_pkg::*;

	logic        rd_wait;
	logic [15:0] load_base;

	// .p images start after the system variables
	assign load_base = (kind == TAPE_P) ? (RAM_LOAD_BASE + P_FILE_OFFSET) : RAM_LOAD_BASE;

	// Wait one cycle for the buffer read, then hold until RAM takes it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_wait      <= 1'b0;
			ram_wr_valid <= 1'b0;
		end else begin
			if (fetch_req) begin
				rd_wait <= 1'b1;
			end else if (rd_wait) begin
				rd_wait      <= 1'b0;
				ram_wr_valid <= 1'b1;
			end
			if (wr_done) begin
				ram_wr_valid <= 1'b0;
			end
		end
	end

	// Byte and address, stable while valid is up
	always_ff @(posedge clk_sys) begin
		if (rd_wait) begin
			ram_wr.data <= rd_data;
			ram_wr.addr <= load_base + RAM_AW'(idx);
		end
	end

	assign wr_done = ram_wr_valid & ram_wr_ready;
	assign busy    = rd_wait | ram_wr_valid;

endmodule

// ==== rtl/zx_tape_loader.sv ====
// ZX80/ZX81 tape fast-loader
// Buffers a downloaded tape image and feeds it into RAM through the ROM trap

`timescale 1ns/1ns

module zx_tape_loader (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_valid,
	input  zx_tape_pkg::dl_beat_t   dl_beat,
	output logic                    dl_ready,
	input  zx_tape_pkg::cpu_fetch_t cpu_fetch,
	input  logic                    zx81,
	input  logic                    ce_cpu_p,
	output logic                    ram_wr_valid,
	output zx_tape_pkg::ram_wr_t    ram_wr,
	input  logic                    ram_wr_ready,
	output zx_tape_pkg::mem_ovr_t   mem_ovr,
	output logic                    tape_ready
);
	import zx_tape_pkg::*;

	tape_idx_t  tape_size;
	tape_kind_t tape_kind;
	tape_byte_t rd_data;
	tape_idx_t  idx;
	logic       at_end;
	logic       loading;
	logic       cnt_clear;
	logic       fetch_req;
	logic       wr_busy;
	logic       wr_done;

	// ========================================================================
	// Tape storage and copy index
	// ========================================================================
	tape_buffer u_tape_buffer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_valid   (dl_valid),
		.dl_beat    (dl_beat),
		.dl_ready   (dl_ready),
		.accept_en  (~loading),
		.rd_idx     (idx),
		.rd_data    (rd_data),
		.tape_size  (tape_size),
		.tape_kind  (tape_kind),
		.tape_ready (tape_ready)
	);

	tape_addr_counter u_tape_addr_counter (
		.clk_sys (clk_sys),
		.reset   (reset),
		.clear   (cnt_clear),
		.step    (wr_done),
		.size    (tape_size),
		.idx     (idx),
		.at_end  (at_end)
	);

	// ========================================================================
	// Trap control, patch and RAM writes
	// ========================================================================
	tape_loader_fsm u_tape_loader_fsm (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_fetch  (cpu_fetch),
		.zx81       (zx81),
		.ce_cpu_p   (ce_cpu_p),
		.tape_ready (tape_ready),
		.at_end     (at_end),
		.wr_busy    (wr_busy),
		.state      (),
		.loading    (loading),
		.cnt_clear  (cnt_clear),
		.fetch_req  (fetch_req)
	);

	loader_patch u_loader_patch (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_fetch  (cpu_fetch),
		.zx81       (zx81),
		.loading    (loading),
		.trap_enter (cnt_clear),
		.at_end     (at_end),
		.mem_ovr    (mem_ovr)
	);

	tape_ram_writer u_tape_ram_writer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.rd_data      (rd_data),
		.idx          (idx),
		.kind         (tape_kind),
		.ram_wr_valid (ram_wr_valid),
		.ram_wr       (ram_wr),
		.ram_wr_ready (ram_wr_ready),
		.busy         (wr_busy),
		.wr_done      (wr_done)
	);

endmodule

// ==== testbench/tb_zx_tape_loader.sv ====
// Testbench for the ZX80/ZX81 tape fast-loader
// Downloads images, traps the load routine and checks patch reads and RAM writes

`timescale 1ns/1ns

module tb_zx_tape_loader;
	import zx_tape_pkg::*;

	localparam int WAIT_LIMIT = 2000;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       dl_valid;
	dl_beat_t   dl_beat;
	logic       dl_ready;
	cpu_fetch_t cpu_fetch;
	logic       zx81;
	logic       ce_cpu_p = 1'b0;
	logic       ram_wr_valid;
	ram_wr_t    ram_wr;
	logic       ram_wr_ready = 1'b0;
	mem_ovr_t   mem_ovr;
	logic       tape_ready;

	int         seed = 45;
	int         errors = 0;
	int         checks = 0;
	logic [1:0] ce_cnt;
	logic       stalled = 1'b0;
	ram_wr_t    held;
	tape_byte_t image_q[$];
	ram_wr_t    writes_q[$];

	zx_tape_loader u_zx_tape_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_valid     (dl_valid),
		.dl_beat      (dl_beat),
		.dl_ready     (dl_ready),
		.cpu_fetch    (cpu_fetch),
		.zx81         (zx81),
		.ce_cpu_p     (ce_cpu_p),
		.ram_wr_valid (ram_wr_valid),
		.ram_wr       (ram_wr),
		.ram_wr_ready (ram_wr_ready),
		.mem_ovr      (mem_ovr),
		.tape_ready   (tape_ready)
	);

	always #50 clk_sys = ~clk_sys;

	// CPU clock enable, one pulse every 4 cycles
	always @(posedge clk_sys) begin
		if (reset) begin
			ce_cnt   <= 2'd0;
			ce_cpu_p <= 1'b0;
		end else begin
			ce_cnt   <= ce_cnt + 2'd1;
			ce_cpu_p <= (ce_cnt == 2'd3);
		end
	end

	// ========================================================================
	// RAM model with random back-pressure
	// ========================================================================
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (ram_wr_valid && ram_wr_ready) begin
				writes_q.push_back(ram_wr);
			end
			// A stalled write must hold still
			if (stalled) begin
				checks++;
				assert (ram_wr_valid) else begin
					errors++;
					$display("Error: time %0t, ram_wr_valid is %b, expected 1",
						$time, ram_wr_valid);
				end
				checks++;
				assert (ram_wr == held) else begin
					errors++;
					$display("Error: time %0t, ram_wr is %h, expected %h", $time, ram_wr, held);
				end
			end
		end
		stalled      <= !reset && ram_wr_valid && !ram_wr_ready;
		held         <= ram_wr;
		ram_wr_ready <= (($random(seed) & 1) != 0);
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout at time %0t while waiting for %s", $time, what);
	endtask

	// Expected patch byte at offset k from the trap address
	function automatic tape_byte_t patch_byte(input int k, input tape_byte_t jump_low,
			input tape_byte_t op1);
		case (k)
			0:       return 8'hAF;
			1:       return op1;
			2:       return 8'h30;
			3:       return 8'hFD;
			4:       return 8'hC3;
			5:       return jump_low;
			6:       return 8'h02;
			default: return 8'hFF;
		endcase
	endfunction

	// Sends one image with last and the kind on the final beat
	task automatic download_image(input tape_kind_t kind, input int len, input int base);
		int t;
		image_q.delete();
		for (int i = 0; i < len; i++) begin
			dl_valid <= 1'b1;
			dl_beat  <= '{8'(base + i * 29), (i == len - 1), kind};
			image_q.push_back(8'(base + i * 29));
			@(posedge clk_sys);
			t = 0;
			while (!dl_ready && t < WAIT_LIMIT) begin
				@(posedge clk_sys);
				t++;
			end
			if (!dl_ready) begin
				report_timeout("dl_ready");
			end
		end
		dl_valid <= 1'b0;
		@(posedge clk_sys);
	endtask

	// One-cycle fetch pulse with the override sampled while the pulse is up
	task automatic fetch_at(input logic [15:0] addr, output mem_ovr_t ovr);
		cpu_fetch <= '{1'b1, addr};
		@(posedge clk_sys);
		ovr = mem_ovr;
		cpu_fetch <= '{1'b0, addr};
		@(posedge clk_sys);
	endtask

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic test_reset_state();
		mem_ovr_t ovr;
		check_value("tape_ready", 16'(tape_ready), 16'h0);
		check_value("dl_ready", 16'(dl_ready), 16'h1);
		check_value("ram_wr_valid", 16'(ram_wr_valid), 16'h0);
		// No tape yet, so the trap address is just a fetch
		fetch_at(16'h0347, ovr);
		check_value("mem_ovr.active", 16'(ovr.active), 16'h0);
		check_value("mem_ovr.active", 16'(mem_ovr.active), 16'h0);
	endtask

	task automatic load_and_check(input logic [15:0] trap, input logic [15:0] ram_base,
			input tape_byte_t jump_low);
		mem_ovr_t ovr;
		int       n;
		int       t;
		n = image_q.size();
		writes_q.delete();
		fetch_at(trap, ovr);
		check_value("mem_ovr.active", 16'(ovr.active), 16'h0);
		check_value("mem_ovr.active", 16'(mem_ovr.active), 16'h1);
		check_value("dl_ready", 16'(dl_ready), 16'h0);
		// Patch bytes while the copy runs and open bus one past the end
		for (int k = 0; k < 8; k++) begin
			fetch_at(trap + 16'(k), ovr);
			check_value("mem_ovr.active", 16'(ovr.active), 16'h1);
			check_value("mem_ovr.data", 16'(ovr.data), 16'(patch_byte(k, jump_low, 8'h00)));
		end
		t = 0;
		while (writes_q.size() < n && t < WAIT_LIMIT) begin
			@(negedge clk_sys);
			t++;
		end
		if (writes_q.size() < n) begin
			report_timeout("RAM writes");
		end
		@(posedge clk_sys);
		repeat (8) @(posedge clk_sys);
		check_value("RAM write count", 16'(writes_q.size()), 16'(n));
		for (int i = 0; i < n && i < writes_q.size(); i++) begin
			check_value("ram_wr.addr", writes_q[i].addr, ram_base + 16'(i));
			check_value("ram_wr.data", 16'(writes_q[i].data), 16'(image_q[i]));
		end
		// Loop exits now that the copy is done
		fetch_at(trap + 16'd1, ovr);
		check_value("mem_ovr.data", 16'(ovr.data), 16'h37);
	endtask

	task automatic exit_trap(input logic [15:0] in_win, input logic [15:0] past_win);
		mem_ovr_t ovr;
		fetch_at(in_win, ovr);
		check_value("mem_ovr.active", 16'(mem_ovr.active), 16'h1);
		fetch_at(past_win, ovr);
		check_value("mem_ovr.active", 16'(mem_ovr.active), 16'h0);
		check_value("dl_ready", 16'(dl_ready), 16'h1);
	endtask

	task automatic test_zx81_p_load();
		download_image(TAPE_P, 5, 8'h5A);
		check_value("tape_ready", 16'(tape_ready), 16'h1);
		load_and_check(16'h0347, 16'h4009, 8'h07);
		exit_trap(16'h03C2, 16'h03C3);
	endtask

	task automatic test_zx80_o_load();
		zx81 <= 1'b0;
		@(posedge clk_sys);
		download_image(TAPE_O, 6, 8'h13);
		check_value("tape_ready", 16'(tape_ready), 16'h1);
		load_and_check(16'h0207, 16'h4000, 8'h03);
		exit_trap(16'h024C, 16'h024D);
	endtask

	initial begin
		reset     <= 1'b1;
		dl_valid  <= 1'b0;
		dl_beat   <= '0;
		cpu_fetch <= '0;
		zx81      <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		test_reset_state();
		test_zx81_p_load();
		test_zx80_o_load();
		finish_run();
	end

endmodule

// ==== files.f ====
rtl/zx_tape_pkg.sv
rtl/tape_buffer.sv
rtl/tape_addr_counter.sv
rtl/tape_loader_fsm.sv
rtl/loader_patch.sv
rtl/tape_ram_writer.sv
rtl/zx_tape_loader.sv
testbench/tb_zx_tape_loader.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tape loader testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f \
	--top-module tb_zx_tape_loader -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
